// ==== hdl/disk_activity_led.sv ====
`timescale 1ns/100ps
`default_nettype none

module disk_activity_led import mac_loader_pkg::*; (
	input  wire logic       clk_sys,
	input  wire logic       n_reset,
	input  wire logic [1:0] disk_act,
	input  wire logic [1:0] disk_motor,
	input  wire logic       download,
	output logic            user_led
);

	logic [LED_HOLD_W-1:0] hold_cnt;
	logic                  held;

	// short activity pulses get stretched so they are visible
	always_ff @(posedge clk_sys) begin
		if (!n_reset)
			hold_cnt <= '0;
		else if (|disk_act)
			hold_cnt <= LED_HOLD_W'(LED_HOLD);
		else if (hold_cnt != '0)
			hold_cnt <= hold_cnt - 1'b1;
	end

	assign held = (hold_cnt != '0);

	// solid during download, activity blinks against a running motor
	assign user_led = download | (held ^ (|disk_motor));

endmodule

`default_nettype wire

// ==== hdl/download_word_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module download_word_buffer import mac_loader_pkg::*; (
	input  wire logic      clk_sys,
	input  wire logic      n_reset,
	input  wire host_dl_t  host,
	input  wire logic      dio_slot,
	output logic           host_wait,
	output dio_word_t      word
);

	logic [7:0] hi_byte;
	logic       old_slot;

	// ========================================================================
	// byte packing
	// ========================================================================
	// even address holds the high byte, odd address closes the word
	always_ff @(posedge clk_sys) begin
		if (host.download && host.wr) begin
			if (!host.addr[0]) begin
				hi_byte <= host.data;
			end else begin
				word.data      <= {hi_byte, host.data};
				word.word_addr <= host.addr[HOST_ADDR_W-1:1];
				word.index     <= host.index;
			end
		end
	end

	// ========================================================================
	// wait and arm sequence
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (!n_reset) begin
			host_wait  <= 1'b0;
			word.write <= 1'b0;
			old_slot   <= 1'b0;
		end else begin
			old_slot <= dio_slot;
			// window just closed with a write in it
			if (old_slot && !dio_slot && word.write) begin
				host_wait  <= 1'b0;
				word.write <= 1'b0;
			end else if (!dio_slot) begin
				// arm only outside the window so a slot is all or nothing
				word.write <= host_wait;
			end
			// a completed word holds the host off
			if (host.download && host.wr && host.addr[0])
				host_wait <= 1'b1;
		end
	end

	// host must respect the wait signal or a word gets overwritten
	a_no_wr_in_wait: assert property (@(posedge clk_sys) disable iff (!n_reset)
		host.wr |-> !host_wait);

endmodule

`default_nettype wire

// ==== hdl/floppy_image_detect.sv ====
`timescale 1ns/100ps
`default_nettype none

module floppy_image_detect import mac_loader_pkg::*; #(
	parameter logic [7:0] DRIVE_INDEX = IDX_DSK1
) (
	input  wire logic                   clk_sys,
	input  wire logic                   n_reset,
	input  wire logic                   download,
	input  wire logic [7:0]             index,
	input  wire logic [WORD_ADDR_W-1:0] word_addr,
	input  wire logic                   eject,
	output logic                        inserted,
	output logic                        double_sided
);

	logic old_down;
	logic single_sided;

	always_ff @(posedge clk_sys) begin
		if (!n_reset) begin
			old_down     <= 1'b0;
			double_sided <= 1'b0;
			single_sided <= 1'b0;
		end else begin
			old_down <= download;
			// the os clears the drive on eject, wins over a late update
			if (eject) begin
				double_sided <= 1'b0;
				single_sided <= 1'b0;
			end else if (old_down && !download && index == DRIVE_INDEX) begin
				// final word address tells the image size
				double_sided <= (word_addr == DS_IMAGE_WORDS);
				single_sided <= (word_addr == SS_IMAGE_WORDS);
			end
		end
	end

	// unknown sizes leave the drive empty
	assign inserted = double_sided | single_sided;

	a_one_kind: assert property (@(posedge clk_sys) disable iff (!n_reset)
		!(double_sided && single_sided));

endmodule

`default_nettype wire

// ==== hdl/mac_loader_pkg.sv ====
`default_nettype none

package mac_loader_pkg;

	// ========================================================================
	// widths
	// ========================================================================
	localparam int HOST_ADDR_W = 25;
	localparam int WORD_ADDR_W = 24;
	localparam int MEM_ADDR_W  = 25;
	localparam int CHIP_ADDR_W = 22;
	// word address inside one image region
	localparam int DIO_A_W     = 21;

	// region bases in words, images sit right after the os rom
	localparam logic [DIO_A_W-1:0] DSK1_BASE = 21'h80000;
	localparam logic [DIO_A_W-1:0] DSK2_BASE = 21'h100000;

	// last word address of a floppy image, 819200 or 409600 bytes
	localparam logic [WORD_ADDR_W-1:0] DS_IMAGE_WORDS = 24'd409600;
	localparam logic [WORD_ADDR_W-1:0] SS_IMAGE_WORDS = 24'd204800;

	// reset stretch in count phases, activity hold in cycles
	localparam int RESET_COUNT = 64;
	localparam int RESET_CNT_W = $clog2(RESET_COUNT + 1);
	localparam int LED_HOLD    = 256;
	localparam int LED_HOLD_W  = $clog2(LED_HOLD + 1);

	// image index codes from the host
	localparam logic [7:0] IDX_ROM  = 8'd0;
	localparam logic [7:0] IDX_DSK1 = 8'd1;
	localparam logic [7:0] IDX_DSK2 = 8'd2;

	// ========================================================================
	// bundles
	// ========================================================================
	typedef struct packed {
		logic                   download;
		logic [7:0]             index;
		logic                   wr;
		logic [HOST_ADDR_W-1:0] addr;
		logic [7:0]             data;
	} host_dl_t;

	typedef struct packed {
		logic [15:0]            data;
		logic [WORD_ADDR_W-1:0] word_addr;
		logic [7:0]             index;
		logic                   write;
	} dio_word_t;

	// chipset side, all strobes active high
	typedef struct packed {
		logic [CHIP_ADDR_W-1:0] addr;
		logic [15:0]            din;
		logic                   uds;
		logic                   lds;
		logic                   rom_oe;
		logic                   ram_oe;
		logic                   ram_we;
		logic                   disk_ack;
	} chip_req_t;

	typedef struct packed {
		logic [MEM_ADDR_W-1:0]  addr;
		logic [15:0]            din;
		logic [1:0]             ds;
		logic                   we;
		logic                   oe;
	} mem_req_t;

endpackage

`default_nettype wire

// ==== hdl/mac_loader_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module mac_loader_top import mac_loader_pkg::*; (
	input  wire logic        clk_sys,
	input  wire logic        n_reset,
	input  wire host_dl_t    host,
	output logic             host_wait,
	input  wire logic        dio_slot,
	input  wire chip_req_t   chip,
	output logic [15:0]      chip_dout,
	output mem_req_t         mem,
	input  wire logic [15:0] mem_dout,
	input  wire logic [1:0]  disk_eject,
	input  wire logic [1:0]  disk_motor,
	input  wire logic [1:0]  disk_act,
	input  wire logic        host_reset,
	input  wire logic        cpu_reset_out,
	input  wire logic [1:0]  mem_select,
	output logic             sys_run,
	output logic [1:0]       ram_size,
	output logic [1:0]       disk_inserted,
	output logic [1:0]       disk_sides,
	output logic             user_led
);

	dio_word_t word;

	// ========================================================================
	// download path
	// ========================================================================
	download_word_buffer u_buffer (
		.clk_sys   (clk_sys),
		.n_reset   (n_reset),
		.host      (host),
		.dio_slot  (dio_slot),
		.host_wait (host_wait),
		.word      (word)
	);

	// bit 0 is the internal drive, bit 1 the external one
	floppy_image_detect #(.DRIVE_INDEX(IDX_DSK1)) u_detect_int (
		.clk_sys      (clk_sys),
		.n_reset      (n_reset),
		.download     (host.download),
		.index        (host.index),
		.word_addr    (word.word_addr),
		.eject        (disk_eject[0]),
		.inserted     (disk_inserted[0]),
		.double_sided (disk_sides[0])
	);

	floppy_image_detect #(.DRIVE_INDEX(IDX_DSK2)) u_detect_ext (
		.clk_sys      (clk_sys),
		.n_reset      (n_reset),
		.download     (host.download),
		.index        (host.index),
		.word_addr    (word.word_addr),
		.eject        (disk_eject[1]),
		.inserted     (disk_inserted[1]),
		.double_sided (disk_sides[1])
	);

	sdram_port_mux u_mux (
		.download  (host.download),
		.dio_slot  (dio_slot),
		.word      (word),
		.chip      (chip),
		.mem       (mem),
		.mem_dout  (mem_dout),
		.chip_dout (chip_dout)
	);

	// ========================================================================
	// system control
	// ========================================================================
	reset_sequencer u_reset (
		.clk_sys       (clk_sys),
		.n_reset       (n_reset),
		.host_reset    (host_reset),
		.cpu_reset_out (cpu_reset_out),
		.mem_select    (mem_select),
		.sys_run       (sys_run),
		.ram_size      (ram_size)
	);

	disk_activity_led u_led (
		.clk_sys    (clk_sys),
		.n_reset    (n_reset),
		.disk_act   (disk_act),
		.disk_motor (disk_motor),
		.download   (host.download),
		.user_led   (user_led)
	);

endmodule

`default_nettype wire

// ==== hdl/reset_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module reset_sequencer import mac_loader_pkg::*; (
	input  wire logic       clk_sys,
	input  wire logic       n_reset,
	input  wire logic       host_reset,
	input  wire logic       cpu_reset_out,
	input  wire logic [1:0] mem_select,
	output logic            sys_run,
	output logic [1:0]      ram_size
);

	logic [2:0]             phase;
	logic [RESET_CNT_W-1:0] rst_cnt;
	logic                   rst_src;

	// eight cycle phase counter gives one stretch step per turn
	always_ff @(posedge clk_sys) begin
		if (!n_reset)
			phase <= 3'd0;
		else
			phase <= phase + 3'd1;
	end

	// any of these holds the machine in reset
	assign rst_src = !n_reset | host_reset | cpu_reset_out;

	always_ff @(posedge clk_sys) begin
		if (rst_src) begin
			rst_cnt <= RESET_CNT_W'(RESET_COUNT);
			sys_run <= 1'b0;
		end else if (rst_cnt != '0) begin
			if (phase == 3'd4)
				rst_cnt <= rst_cnt - 1'b1;
			// ram size is only taken while the machine is held
			ram_size <= mem_select + 2'd1;
		end else begin
			sys_run <= 1'b1;
		end
	end

	// a stretch in progress keeps the machine held
	a_held_while_count: assert property (@(posedge clk_sys) disable iff (!n_reset)
		(rst_cnt != '0) |-> !sys_run);

endmodule

`default_nettype wire

// ==== hdl/sdram_port_mux.sv ====
`timescale 1ns/100ps
`default_nettype none

module sdram_port_mux import mac_loader_pkg::*; (
	input  wire logic        download,
	input  wire logic        dio_slot,
	input  wire dio_word_t   word,
	input  wire chip_req_t   chip,
	output mem_req_t         mem,
	input  wire logic [15:0] mem_dout,
	output logic [15:0]      chip_dout
);

	logic               download_cycle;
	logic [DIO_A_W-1:0] dio_a;
	logic [15:0]        disk_byte;

	// the download owns the port only inside its slot
	assign download_cycle = download & dio_slot;

	// ========================================================================
	// region mapping
	// ========================================================================
	always_comb begin
		case (word.index)
			IDX_ROM:  dio_a = word.word_addr[DIO_A_W-1:0];
			IDX_DSK1: dio_a = DSK1_BASE + word.word_addr[DIO_A_W-1:0];
			default:  dio_a = DSK2_BASE + word.word_addr[DIO_A_W-1:0];
		endcase
	end

	// ========================================================================
	// request mux
	// ========================================================================
	// download region sits above the chipset space, rom select above ram
	assign mem.addr = download_cycle ? {4'b0001, dio_a}
	                                 : {3'b000, chip.rom_oe, chip.addr[CHIP_ADDR_W-1:1]};
	assign mem.din  = download_cycle ? word.data : chip.din;
	assign mem.ds   = download_cycle ? 2'b11 : {chip.uds, chip.lds};
	assign mem.we   = download_cycle ? word.write : chip.ram_we;
	assign mem.oe   = download_cycle ? 1'b0 : (chip.ram_oe | chip.rom_oe);

	// ========================================================================
	// read data
	// ========================================================================
	// disk images are byte wide, pick the byte and copy it to both halves
	assign disk_byte = chip.addr[0] ? {mem_dout[7:0], mem_dout[7:0]}
	                                : {mem_dout[15:8], mem_dout[15:8]};

	// chipset sees an idle bus while the loader has the slot
	assign chip_dout = download_cycle ? 16'hffff
	                 : chip.disk_ack  ? disk_byte
	                 : mem_dout;

endmodule

`default_nettype wire

// ==== mac_loader.f ====
hdl/mac_loader_pkg.sv
hdl/download_word_buffer.sv
hdl/floppy_image_detect.sv
hdl/sdram_port_mux.sv
hdl/reset_sequencer.sv
hdl/disk_activity_led.sv
hdl/mac_loader_top.sv
tb/tb_mac_loader.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the mac_loader testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_mac_loader -Mdir obj_dir -o sim_mac_loader \
	-f mac_loader.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_mac_loader > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q '^>>> PASS$' sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1

// ==== tb/mac_loader_cases.txt ====
# op f1 f2 f3 f4 f5, all fields hex
# dl: index, first word address, word count, disk_inserted, disk_sides after it
# rd: rom_oe, chipset byte address, mem_dout, disk_ack, chip_dout
# ej: eject mask, unused, unused, disk_inserted, disk_sides
# rs: source (0 host_reset, 1 cpu_reset_out), mem_select, ram_size, cycles held, unused
# ld: disk_act pulse, disk_motor, download, cycles waited, user_led
dl 0 000000 4 0 0
dl 0 01fffe 3 0 0
dl 1 063ffe 3 1 1
dl 2 031ffd 4 3 1
ej 1 0 0 2 0
dl 1 031fff 2 3 0
dl 2 064000 1 3 2
dl 2 001000 5 1 0
ej 3 0 0 0 0
dl 1 063fff 2 1 1
dl 0 064000 1 1 1
ej 1 0 0 0 0
rd 0 001234 a1b2 0 a1b2
rd 1 000457 c3d4 0 c3d4
rd 0 100000 5e6f 1 5e5e
rd 0 100001 5e6f 1 6f6f
rd 1 3fffff 0f1e 1 1e1e
rs 0 1 2 5 0
rs 1 3 0 3 0
ld 1 0 0 a 1
ld 0 0 0 12c 0
ld 1 1 0 a 0
ld 0 2 0 12c 1
ld 0 0 1 2 1
ld 1 0 0 100 1
ld 1 0 0 101 0

// ==== tb/tb_mac_loader.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_mac_loader import mac_loader_pkg::*; ();

	// one memory write as the external memory should see it
	typedef struct packed {
		logic [MEM_ADDR_W-1:0] addr;
		logic [15:0]           data;
	} mem_wr_t;

	// one record of the case file with its fields in file order
	typedef struct packed {
		logic [31:0] f1;
		logic [31:0] f2;
		logic [31:0] f3;
		logic [31:0] f4;
		logic [31:0] f5;
	} case_rec_t;

	logic        clk_sys;
	logic        n_reset;
	host_dl_t    host;
	logic        host_wait;
	logic        dio_slot;
	chip_req_t   chip;
	logic [15:0] chip_dout;
	mem_req_t    mem;
	logic [15:0] mem_dout;
	logic [1:0]  disk_eject;
	logic [1:0]  disk_motor;
	logic [1:0]  disk_act;
	logic        host_reset;
	logic        cpu_reset_out;
	logic [1:0]  mem_select;
	logic        sys_run;
	logic [1:0]  ram_size;
	logic [1:0]  disk_inserted;
	logic [1:0]  disk_sides;
	logic        user_led;

	string     ops[$];
	case_rec_t recs[$];
	// words sent by the host and not yet seen at the memory port
	mem_wr_t   exp_q[$];
	integer    seed = 32'h9f3a_1925;
	int        errors = 0;
	int        cycles = 0;
	int        cycle_limit = 2000;
	logic      wr_seen = 1'b0;

	mac_loader_top DUT (.*);

	// ========================================================================
	// clock, slot windows and watchdog
	// ========================================================================
	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// one 2 cycle window per 8 cycle frame at a random offset
	initial begin : slot_gen
		logic [31:0] rnd;
		logic [2:0]  offs;
		dio_slot = 1'b0;
		forever begin
			rnd  = $random(seed);
			offs = (rnd[2:0] == 3'd7) ? 3'd6 : rnd[2:0];
			for (int i = 0; i < 8; i++) begin
				@(negedge clk_sys);
				dio_slot = (i == offs) || (i == offs + 1);
			end
		end
	end

	always @(posedge clk_sys) begin
		cycles = cycles + 1;
		if (cycles > cycle_limit) begin
			$display("timeout after %0d cycles with %0d errors counted", cycles, errors);
			$display(">>> FAIL");
			$finish;
		end
	end

	// ========================================================================
	// memory port monitor
	// ========================================================================
	// a write window counts once however many cycles we stays up
	always @(posedge clk_sys) begin : write_monitor
		mem_wr_t exp;
		if (n_reset && host.download && dio_slot) begin
			// chipset is locked out of the download slot
			if (chip_dout !== 16'hffff)
				report_mismatch("chip_dout", chip_dout, 32'hffff);
			if (mem.we && !wr_seen) begin
				if (exp_q.size() == 0) begin
					$display("memory write at address 0x%h with no word pending", mem.addr);
					errors++;
				end else begin
					exp = exp_q.pop_front();
					if (mem.addr !== exp.addr)
						report_mismatch("mem.addr", mem.addr, exp.addr);
					if (mem.din !== exp.data)
						report_mismatch("mem.din", mem.din, exp.data);
					if (mem.ds !== 2'b11)
						report_mismatch("mem.ds", mem.ds, 2'b11);
					if (mem.oe !== 1'b0)
						report_mismatch("mem.oe", mem.oe, 0);
				end
			end
		end
		wr_seen = n_reset && host.download && dio_slot && mem.we;
	end

	function automatic void report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		errors++;
	endfunction

	// rom region at the bottom with the floppy images above it
	function automatic logic [MEM_ADDR_W-1:0] region_addr(input logic [7:0] idx,
		input logic [WORD_ADDR_W-1:0] waddr);
		logic [DIO_A_W-1:0] base;
		logic [DIO_A_W-1:0] offs;
		if (idx == IDX_ROM)
			base = '0;
		else if (idx == IDX_DSK1)
			base = DSK1_BASE;
		else
			base = DSK2_BASE;
		offs = base + waddr[DIO_A_W-1:0];
		return {4'b0001, offs};
	endfunction

	// ========================================================================
	// case file
	// ========================================================================
	task automatic load_cases();
		int          fd;
		int          n;
		string       line;
		string       op;
		logic [31:0] v1;
		logic [31:0] v2;
		logic [31:0] v3;
		logic [31:0] v4;
		logic [31:0] v5;
		fd = $fopen("tb/mac_loader_cases.txt", "r");
		if (fd == 0) begin
			$display("cannot open the case file tb/mac_loader_cases.txt");
			errors++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				// skip blank lines and the column notes
				if (line.len() > 1 && line.getc(0) != "#") begin
					v1 = '0;
					v2 = '0;
					v3 = '0;
					v4 = '0;
					v5 = '0;
					n  = $sscanf(line, "%s %h %h %h %h %h", op, v1, v2, v3, v4, v5);
					if (n >= 1) begin
						ops.push_back(op);
						recs.push_back({v1, v2, v3, v4, v5});
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// ========================================================================
	// host download
	// ========================================================================
	task automatic send_byte(input logic [HOST_ADDR_W-1:0] addr, input logic [7:0] data);
		// host only writes while the loader lets it
		while (host_wait)
			@(negedge clk_sys);
		host.wr   = 1'b1;
		host.addr = addr;
		host.data = data;
		@(negedge clk_sys);
		host.wr = 1'b0;
		// odd byte closes the word and holds the host off at once
		if (addr[0] && host_wait !== 1'b1)
			report_mismatch("host_wait", host_wait, 1);
	endtask

	task automatic download_image(input logic [7:0] idx, input logic [WORD_ADDR_W-1:0] start,
		input int count, input logic [1:0] exp_ins, input logic [1:0] exp_sides);
		logic [31:0]            rnd;
		logic [WORD_ADDR_W-1:0] waddr;
		host.download = 1'b1;
		host.index    = idx;
		mem_dout      = 16'h5aa5;
		for (int w = 0; w < count; w++) begin
			rnd   = $random(seed);
			waddr = start + WORD_ADDR_W'(w);
			exp_q.push_back({region_addr(idx, waddr), rnd[15:0]});
			// idle gaps on the host side shift the words against the slots
			repeat (rnd[17:16]) @(negedge clk_sys);
			send_byte({waddr, 1'b0}, rnd[15:8]);
			send_byte({waddr, 1'b1}, rnd[7:0]);
		end
		// last word has to pass a slot before the download may end
		while (host_wait)
			@(negedge clk_sys);
		host.download = 1'b0;
		mem_dout      = 16'h0000;
		repeat (3) @(negedge clk_sys);
		if (exp_q.size() != 0) begin
			$display("%0d memory writes missing after the download of index %0d",
				exp_q.size(), idx);
			errors++;
			exp_q.delete();
		end
		if (disk_inserted !== exp_ins)
			report_mismatch("disk_inserted", disk_inserted, exp_ins);
		if (disk_sides !== exp_sides)
			report_mismatch("disk_sides", disk_sides, exp_sides);
	endtask

	// ========================================================================
	// chipset, eject, reset and light
	// ========================================================================
	task automatic read_chipset(input logic rom, input logic [CHIP_ADDR_W-1:0] addr,
		input logic [15:0] rdata, input logic ack, input logic [15:0] exp_dout);
		logic [MEM_ADDR_W-1:0] exp_addr;
		logic [15:0]           exp_din;
		logic [1:0]            exp_ds;
		// word address is the byte address halved with rom select one bit above it
		exp_addr = MEM_ADDR_W'(addr / 2);
		if (rom)
			exp_addr = exp_addr + (MEM_ADDR_W'(1) << (CHIP_ADDR_W - 1));
		// upper byte strobe on even addresses and lower on odd ones
		exp_ds        = addr[0] ? 2'b01 : 2'b10;
		exp_din       = ~rdata;
		chip          = '0;
		chip.addr     = addr;
		chip.din      = exp_din;
		chip.rom_oe   = rom;
		chip.ram_oe   = !rom;
		chip.uds      = !addr[0];
		chip.lds      = addr[0];
		chip.disk_ack = ack;
		mem_dout      = rdata;
		@(negedge clk_sys);
		if (mem.addr !== exp_addr)
			report_mismatch("mem.addr", mem.addr, exp_addr);
		if (mem.din !== exp_din)
			report_mismatch("mem.din", mem.din, exp_din);
		if (mem.ds !== exp_ds)
			report_mismatch("mem.ds", mem.ds, exp_ds);
		if (mem.oe !== 1'b1)
			report_mismatch("mem.oe", mem.oe, 1);
		if (mem.we !== 1'b0)
			report_mismatch("mem.we", mem.we, 0);
		if (chip_dout !== exp_dout)
			report_mismatch("chip_dout", chip_dout, exp_dout);
		chip     = '0;
		mem_dout = '0;
	endtask

	task automatic eject_disks(input logic [1:0] mask, input logic [1:0] exp_ins,
		input logic [1:0] exp_sides);
		disk_eject = mask;
		@(negedge clk_sys);
		disk_eject = 2'b00;
		if (disk_inserted !== exp_ins)
			report_mismatch("disk_inserted", disk_inserted, exp_ins);
		if (disk_sides !== exp_sides)
			report_mismatch("disk_sides", disk_sides, exp_sides);
	endtask

	task automatic hold_reset(input logic sel, input logic [1:0] msel,
		input logic [1:0] exp_size, input int hold);
		int n;
		mem_select = msel;
		if (sel)
			cpu_reset_out = 1'b1;
		else
			host_reset = 1'b1;
		repeat (hold) begin
			@(negedge clk_sys);
			if (sys_run !== 1'b0)
				report_mismatch("sys_run", sys_run, 0);
		end
		host_reset    = 1'b0;
		cpu_reset_out = 1'b0;
		// count cycles from the release to the rise of sys_run
		n = 0;
		while (!sys_run && n < RESET_COUNT * 8 + 16) begin
			@(negedge clk_sys);
			n++;
		end
		if (!sys_run) begin
			$display("sys_run did not rise within %0d cycles of the reset release", n);
			errors++;
		end else if (n < RESET_COUNT * 8 - 8 || n > RESET_COUNT * 8 + 8) begin
			$display("sys_run rose %0d cycles after the reset release, outside %0d to %0d",
				n, RESET_COUNT * 8 - 8, RESET_COUNT * 8 + 8);
			errors++;
		end
		if (ram_size !== exp_size)
			report_mismatch("ram_size", ram_size, exp_size);
	endtask

	// wait counts cycles from the one that carries the activity pulse
	task automatic drive_activity(input logic act, input logic [1:0] motor, input logic dl,
		input int wait_cycles, input logic exp_led);
		disk_motor    = motor;
		host.index    = IDX_ROM;
		host.download = dl;
		disk_act      = {1'b0, act};
		@(negedge clk_sys);
		disk_act = 2'b00;
		repeat (wait_cycles - 1) @(negedge clk_sys);
		if (user_led !== exp_led)
			report_mismatch("user_led", user_led, exp_led);
		disk_motor    = 2'b00;
		host.download = 1'b0;
	endtask

	task automatic dispatch_case(input string op, input case_rec_t rec, input int num);
		if (op == "dl")
			download_image(rec.f1[7:0], rec.f2[WORD_ADDR_W-1:0], rec.f3, rec.f4[1:0],
				rec.f5[1:0]);
		else if (op == "rd")
			read_chipset(rec.f1[0], rec.f2[CHIP_ADDR_W-1:0], rec.f3[15:0], rec.f4[0],
				rec.f5[15:0]);
		else if (op == "ej")
			eject_disks(rec.f1[1:0], rec.f4[1:0], rec.f5[1:0]);
		else if (op == "rs")
			hold_reset(rec.f1[0], rec.f2[1:0], rec.f3[1:0], rec.f4);
		else if (op == "ld")
			drive_activity(rec.f1[0], rec.f2[1:0], rec.f3[0], rec.f4, rec.f5[0]);
		else begin
			$display("unknown opcode %s in case %0d", op, num);
			errors++;
		end
	endtask

	// ========================================================================
	// main sequence
	// ========================================================================
	initial begin : main_seq
		n_reset       = 1'b0;
		host          = '0;
		chip          = '0;
		mem_dout      = '0;
		disk_eject    = '0;
		disk_motor    = '0;
		disk_act      = '0;
		host_reset    = 1'b0;
		cpu_reset_out = 1'b0;
		mem_select    = '0;
		load_cases();
		cycle_limit = 200 * ops.size() + 2000;
		repeat (3) @(negedge clk_sys);
		// everything quiet straight out of reset
		if (host_wait !== 1'b0)
			report_mismatch("host_wait", host_wait, 0);
		if (DUT.word.write !== 1'b0)
			report_mismatch("word.write", DUT.word.write, 0);
		if (sys_run !== 1'b0)
			report_mismatch("sys_run", sys_run, 0);
		if (user_led !== 1'b0)
			report_mismatch("user_led", user_led, 0);
		if (disk_inserted !== 2'b00)
			report_mismatch("disk_inserted", disk_inserted, 0);
		if (disk_sides !== 2'b00)
			report_mismatch("disk_sides", disk_sides, 0);
		n_reset = 1'b1;
		foreach (ops[i])
			dispatch_case(ops[i], recs[i], i);
		$display("cases run: %0d, errors: %0d", ops.size(), errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire
